//--- core_macros.svh
/*
 * Core-wide constants
 *   data and pc width, register and hart counts
 *   RV32I major opcode field values
 */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

//////////////////////////////
// Widths and counts
//////////////////////////////
`define WORD_W     32                    // Data and pc width
`define REG_NUM    32                    // Registers per hart
`define REG_AW     ($clog2(`REG_NUM))    // Register address width
`define HART_NUM   4                     // 2 or 8 also work
`define HART_W     ($clog2(`HART_NUM))   // Hart id width

//////////////////////////////
// RV32I major opcodes
//////////////////////////////
`define OPC_OP     7'b0110011            // Register-register ALU
`define OPC_OPIMM  7'b0010011            // Register-immediate ALU
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011            // LW only
`define OPC_STORE  7'b0100011            // SW only
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111

`endif

//--- core_pkg.sv
/*
 * Shared decode types
 *   ALU, compare, memory, bypass and exception enums
 *   ID/EX pipeline content and writeback port structs
 */
`include "core_macros.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,                  // Zero so reset and bubbles decode as NOP
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                         // Signed compare
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NONE = 3'd0,                 // Not a branch
        CMP_EQ,
        CMP_NE,
        CMP_LT,                          // Signed
        CMP_GE                           // Signed
    } cmp_op_e;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_LW,
        MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        FWD_GPR = 2'd0,                  // Register file value
        FWD_EX,                          // Bypass from EX result
        FWD_MEM                          // Bypass from MEM result
    } fwd_ctrl_e;

    typedef enum logic [1:0] {
        EXP_NONE    = 2'd0,
        EXP_ILLEGAL
    } exp_code_e;

    // Everything EX needs for one instruction
    typedef struct packed {
        logic               en;          // Slot valid
        logic [`HART_W-1:0] hart_id;
        logic [`WORD_W-1:0] pc;
        alu_op_e            alu_op;
        logic [`WORD_W-1:0] alu_in_0;
        logic [`WORD_W-1:0] alu_in_1;
        cmp_op_e            cmp_op;
        logic [`WORD_W-1:0] cmp_in_0;
        logic [`WORD_W-1:0] cmp_in_1;
        logic               jump_taken;  // Unconditional jump
        logic               is_jalr;
        mem_op_e            mem_op;
        logic [`WORD_W-1:0] mem_wr_data; // Store data
        logic [`REG_AW-1:0] rd_addr;
        logic               gpr_we;
        logic [`WORD_W-1:0] gpr_wr_data; // Link value for jumps
        exp_code_e          exp_code;
    } id_ex_t;

    typedef struct packed {
        logic               we;
        logic [`HART_W-1:0] hart_id;
        logic [`REG_AW-1:0] addr;
        logic [`WORD_W-1:0] data;
    } wb_t;

endpackage

//--- gpr_file.sv
/*
 * Banked general register file
 *   one bank of registers per hart
 *   two combinational read ports, one write port
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module gpr_file import core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_t                wb,       // Writeback port
    input  logic [`HART_W-1:0] rs1_hart, // Bank for both reads
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    output logic [`WORD_W-1:0] rs1_data,
    output logic [`WORD_W-1:0] rs2_data
);

    logic [`WORD_W-1:0] regs [`HART_NUM][`REG_NUM]; // Hart x register

    // Reads see the pre-write contents in the write cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_hart][rs1_addr]; // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs1_hart][rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};              // Clear every bank
        end else if (wb.we && (wb.addr != '0)) begin
            regs[wb.hart_id][wb.addr] <= wb.data; // x0 writes dropped
        end
    end

    // Writeback must address an existing bank
    a_wb_hart_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.we |-> (wb.hart_id < `HART_NUM)
    );

endmodule

//--- fwd_unit.sv
/*
 * Forwarding control
 *   compares decode sources with EX and MEM destinations
 *   EX hit wins over MEM hit, otherwise register file
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module fwd_unit import core_pkg::*; (
    input  logic [`HART_W-1:0] id_hart_id,   // Hart of the instruction in decode
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic [1:0]         src_reg_used, // Bit 0 rs1, bit 1 rs2
    input  id_ex_t             ex_stage,     // Instruction now in EX
    input  logic [`HART_W-1:0] mem_hart_id,
    input  logic [`REG_AW-1:0] mem_rd_addr,
    input  logic               mem_gpr_we,
    output fwd_ctrl_e          rs1_fwd_ctrl,
    output fwd_ctrl_e          rs2_fwd_ctrl
);

    // Select for one source operand
    function automatic fwd_ctrl_e fwd_pick(logic used, logic [`REG_AW-1:0] rs);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex_stage.en && ex_stage.gpr_we && (ex_stage.hart_id == id_hart_id)
                  && (ex_stage.rd_addr == rs);
        mem_hit = mem_gpr_we && (mem_hart_id == id_hart_id) && (mem_rd_addr == rs);
        if (!used || (rs == '0)) begin
            return FWD_GPR;                  // Unused source or x0
        end else if (ex_hit) begin
            return FWD_EX;                   // Youngest producer first
        end else if (mem_hit) begin
            return FWD_MEM;
        end
        return FWD_GPR;
    endfunction

    always_comb begin
        rs1_fwd_ctrl = fwd_pick(src_reg_used[0], rs1_addr);
        rs2_fwd_ctrl = fwd_pick(src_reg_used[1], rs2_addr);
    end

    // x0 is constant, so a bypass for it would corrupt the operand
    always_comb begin
        if (!$isunknown({rs1_addr, rs2_addr})) begin
            a_no_fwd_x0 : assert ((rs1_addr != '0 || rs1_fwd_ctrl == FWD_GPR)
                                  && (rs2_addr != '0 || rs2_fwd_ctrl == FWD_GPR));
        end
    end

endmodule

//--- decoder.sv
/*
 * RV32I subset decoder
 *   field extraction and I, S, B, U, J immediates
 *   ALU, compare and memory operation select
 *   illegal opcode and funct detection
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module decoder import core_pkg::*; (
    input  logic               if_en,        // Fetch slot valid
    input  logic [`WORD_W-1:0] pc,
    input  logic [`WORD_W-1:0] insn,
    input  logic [`WORD_W-1:0] rs1_data,     // Operand after bypass
    input  logic [`WORD_W-1:0] rs2_data,
    output logic [`REG_AW-1:0] rs1_addr,     // To register file and forwarding
    output logic [`REG_AW-1:0] rs2_addr,
    output logic [1:0]         src_reg_used, // Bit 0 rs1, bit 1 rs2
    output id_ex_t             decoded       // Hart id left zero here
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`WORD_W-1:0] imm_i;
    logic [`WORD_W-1:0] imm_s;
    logic [`WORD_W-1:0] imm_b;
    logic [`WORD_W-1:0] imm_u;
    logic [`WORD_W-1:0] imm_j;
    alu_op_e            funct_op;            // ALU op from funct fields
    logic               funct_ok;
    logic               illegal;

    //////////////////////////////
    // Fields and immediates
    //////////////////////////////
    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    // funct decode shared by OP and OP-IMM
    always_comb begin
        funct_ok = 1'b1;
        case (funct3)
            3'b000: funct_op = (opcode == `OPC_OP && funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
            3'b001: funct_op = ALU_SLL;
            3'b010: funct_op = ALU_SLT;
            3'b100: funct_op = ALU_XOR;
            3'b101: funct_op = ALU_SRL;
            3'b110: funct_op = ALU_OR;
            3'b111: funct_op = ALU_AND;
            default: begin
                funct_op = ALU_NOP;          // SLTU not supported
                funct_ok = 1'b0;
            end
        endcase
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
            funct_ok = funct_ok && (funct7 == 7'b0);          // Logical shifts only
        end else if (opcode == `OPC_OP && funct3 == 3'b000) begin
            funct_ok = (funct7 == 7'b0) || (funct7 == 7'b0100000); // ADD or SUB
        end else if (opcode == `OPC_OP) begin
            funct_ok = funct_ok && (funct7 == 7'b0);
        end
    end

    //////////////////////////////
    // Per-opcode decode
    //////////////////////////////
    always_comb begin
        decoded          = '0;
        src_reg_used     = 2'b00;
        illegal          = 1'b0;
        decoded.en       = if_en;
        decoded.pc       = pc;
        decoded.rd_addr  = insn[11:7];
        decoded.alu_in_0 = rs1_data;         // Default operand pair
        decoded.alu_in_1 = imm_i;
        case (opcode)
            `OPC_OP: begin
                decoded.alu_op   = funct_op;
                decoded.alu_in_1 = rs2_data;
                decoded.gpr_we   = 1'b1;
                src_reg_used     = 2'b11;
                illegal          = !funct_ok;
            end
            `OPC_OPIMM: begin
                decoded.alu_op = funct_op;
                decoded.gpr_we = 1'b1;
                src_reg_used   = 2'b01;
                illegal        = !funct_ok;
            end
            `OPC_LUI: begin
                decoded.alu_op   = ALU_ADD;      // 0 + imm
                decoded.alu_in_0 = '0;
                decoded.alu_in_1 = imm_u;
                decoded.gpr_we   = 1'b1;
            end
            `OPC_AUIPC: begin
                decoded.alu_op   = ALU_ADD;      // pc + imm
                decoded.alu_in_0 = pc;
                decoded.alu_in_1 = imm_u;
                decoded.gpr_we   = 1'b1;
            end
            `OPC_LOAD: begin
                decoded.alu_op = ALU_ADD;        // Address calc
                decoded.mem_op = MEM_LW;
                decoded.gpr_we = 1'b1;
                src_reg_used   = 2'b01;
            end
            `OPC_STORE: begin
                decoded.alu_op      = ALU_ADD;
                decoded.alu_in_1    = imm_s;
                decoded.mem_op      = MEM_SW;
                decoded.mem_wr_data = rs2_data;
                src_reg_used        = 2'b11;
            end
            `OPC_BRANCH: begin
                decoded.alu_in_1 = imm_b;
                decoded.cmp_in_0 = rs1_data;
                decoded.cmp_in_1 = rs2_data;
                src_reg_used     = 2'b11;
                case (funct3)
                    3'b000:  decoded.cmp_op = CMP_EQ;
                    3'b001:  decoded.cmp_op = CMP_NE;
                    3'b100:  decoded.cmp_op = CMP_LT;
                    3'b101:  decoded.cmp_op = CMP_GE;
                    default: decoded.cmp_op = CMP_NONE; // BLTU and BGEU not taken
                endcase
            end
            `OPC_JAL: begin
                decoded.alu_op      = ALU_ADD;   // Jump target
                decoded.alu_in_0    = pc;
                decoded.alu_in_1    = imm_j;
                decoded.jump_taken  = 1'b1;
                decoded.gpr_we      = 1'b1;
                decoded.gpr_wr_data = pc + 'd4;  // Link address
            end
            `OPC_JALR: begin
                decoded.alu_op      = ALU_ADD;
                decoded.alu_in_0    = pc;
                decoded.is_jalr     = 1'b1;
                decoded.gpr_we      = 1'b1;
                decoded.gpr_wr_data = pc + 'd4;
                src_reg_used        = 2'b01;
            end
            default: illegal = 1'b1;         // Unknown major opcode
        endcase
        if (illegal) begin
            decoded.exp_code = EXP_ILLEGAL;
            decoded.gpr_we   = 1'b0;
            decoded.mem_op   = MEM_NONE;
        end
        if (!if_en) begin                    // Empty slot has no side effects
            decoded.gpr_we = 1'b0;
            decoded.mem_op = MEM_NONE;
        end
    end

endmodule

//--- id_reg.sv
/*
 * ID/EX pipeline register
 *   flush loads a bubble, stall holds, else loads decode
 */
`timescale 1ns/1ps

module id_reg import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,    // Hold current content
    input  logic   flush,    // Kill slot even when stalled
    input  id_ex_t decoded,  // Next content from decode
    output id_ex_t id_ex     // Instruction in EX
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;             // en low, no write, MEM_NONE
        end else if (flush) begin
            id_ex <= '0;             // Bubble
        end else if (!stall) begin
            id_ex <= decoded;
        end
    end

    // A flushed slot never reaches EX as valid
    a_flush_bubble : assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !id_ex.en
    );

endmodule

//--- id_stage.sv
/*
 * Instruction decode stage
 *   operand bypass multiplexers
 *   decoder and ID/EX register
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module id_stage import core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               if_en,         // Fetch slot valid
    input  logic [`HART_W-1:0] if_hart_id,
    input  logic [`WORD_W-1:0] if_pc,
    input  logic [`WORD_W-1:0] if_insn,
    input  logic [`WORD_W-1:0] gpr_rs1_data,  // Register file reads
    input  logic [`WORD_W-1:0] gpr_rs2_data,
    input  logic [`WORD_W-1:0] ex_fwd_data,   // EX result bypass
    input  logic [`WORD_W-1:0] mem_fwd_data,  // MEM result bypass
    input  fwd_ctrl_e          rs1_fwd_ctrl,
    input  fwd_ctrl_e          rs2_fwd_ctrl,
    output logic [`REG_AW-1:0] gpr_rs1_addr,
    output logic [`REG_AW-1:0] gpr_rs2_addr,
    output logic [1:0]         src_reg_used,
    output id_ex_t             id_ex
);

    logic [`WORD_W-1:0] rs1_data;     // Operand after bypass
    logic [`WORD_W-1:0] rs2_data;
    id_ex_t             dec_out;      // Decoder result
    id_ex_t             stage_next;   // With hart id attached

    function automatic logic [`WORD_W-1:0] fwd_mux(fwd_ctrl_e sel, logic [`WORD_W-1:0] gpr);
        case (sel)
            FWD_EX:  return ex_fwd_data;
            FWD_MEM: return mem_fwd_data;
            default: return gpr;      // No hazard
        endcase
    endfunction

    always_comb begin
        rs1_data = fwd_mux(rs1_fwd_ctrl, gpr_rs1_data);
        rs2_data = fwd_mux(rs2_fwd_ctrl, gpr_rs2_data);
    end

    decoder u_decoder (
        .if_en        (if_en),
        .pc           (if_pc),
        .insn         (if_insn),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_addr     (gpr_rs1_addr),
        .rs2_addr     (gpr_rs2_addr),
        .src_reg_used (src_reg_used),
        .decoded      (dec_out)
    );

    always_comb begin
        stage_next         = dec_out;
        stage_next.hart_id = if_hart_id;  // Tag slot with its hart
    end

    id_reg u_id_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .flush   (flush),
        .decoded (stage_next),
        .id_ex   (id_ex)
    );

endmodule

//--- decode_top.sv
/*
 * Decode top level
 *   banked register file, forwarding control, decode stage
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module decode_top import core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               if_en,
    input  logic [`HART_W-1:0] if_hart_id,
    input  logic [`WORD_W-1:0] if_pc,
    input  logic [`WORD_W-1:0] if_insn,
    input  wb_t                wb,           // Writeback into banks
    input  logic [`WORD_W-1:0] ex_fwd_data,
    input  logic [`WORD_W-1:0] mem_fwd_data,
    input  logic [`HART_W-1:0] mem_hart_id,  // MEM destination
    input  logic [`REG_AW-1:0] mem_rd_addr,
    input  logic               mem_gpr_we,
    output id_ex_t             id_ex         // To EX
);

    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`WORD_W-1:0] rs1_data;
    logic [`WORD_W-1:0] rs2_data;
    logic [1:0]         src_reg_used;
    fwd_ctrl_e          rs1_fwd_ctrl;
    fwd_ctrl_e          rs2_fwd_ctrl;

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1_hart (if_hart_id),      // Both reads from decode hart
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    fwd_unit u_fwd_unit (
        .id_hart_id   (if_hart_id),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .src_reg_used (src_reg_used),
        .ex_stage     (id_ex),       // Registered slot is the EX instruction
        .mem_hart_id  (mem_hart_id),
        .mem_rd_addr  (mem_rd_addr),
        .mem_gpr_we   (mem_gpr_we),
        .rs1_fwd_ctrl (rs1_fwd_ctrl),
        .rs2_fwd_ctrl (rs2_fwd_ctrl)
    );

    id_stage u_id_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .if_en        (if_en),
        .if_hart_id   (if_hart_id),
        .if_pc        (if_pc),
        .if_insn      (if_insn),
        .gpr_rs1_data (rs1_data),
        .gpr_rs2_data (rs2_data),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_data (mem_fwd_data),
        .rs1_fwd_ctrl (rs1_fwd_ctrl),
        .rs2_fwd_ctrl (rs2_fwd_ctrl),
        .gpr_rs1_addr (rs1_addr),
        .gpr_rs2_addr (rs2_addr),
        .src_reg_used (src_reg_used),
        .id_ex        (id_ex)
    );

endmodule

//--- tb_decode_top.sv
/*
 * Testbench for the decode top level
 *   random instruction, writeback, MEM and bypass stimulus
 *   reference model of register banks, forwarding, decode and ID/EX register
 *   field by field compare of id_ex every cycle
 */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_decode_top import core_pkg::*; ();

    localparam int NUM_CYCLES = 4000;        // Random cycles after reset
    localparam int DRAIN_MAX  = 8;           // Edges allowed to empty the slot

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               flush;
    logic               if_en;
    logic [`HART_W-1:0] if_hart_id;
    logic [`WORD_W-1:0] if_pc;
    logic [`WORD_W-1:0] if_insn;
    wb_t                wb;
    logic [`WORD_W-1:0] ex_fwd_data;
    logic [`WORD_W-1:0] mem_fwd_data;
    logic [`HART_W-1:0] mem_hart_id;
    logic [`REG_AW-1:0] mem_rd_addr;
    logic               mem_gpr_we;
    id_ex_t             id_ex;

    id_ex_t             exp_q;                               // Model of the ID/EX slot
    logic [`WORD_W-1:0] gpr_model [`HART_NUM][`REG_NUM];     // Model register banks

    decode_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .if_en        (if_en),
        .if_hart_id   (if_hart_id),
        .if_pc        (if_pc),
        .if_insn      (if_insn),
        .wb           (wb),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_data (mem_fwd_data),
        .mem_hart_id  (mem_hart_id),
        .mem_rd_addr  (mem_rd_addr),
        .mem_gpr_we   (mem_gpr_we),
        .id_ex        (id_ex)
    );

    always #10 clk = ~clk;                   // 20 ns period

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Operand seen by decode with EX ahead of MEM
    function automatic logic [`WORD_W-1:0] src_value(logic used, logic [`REG_AW-1:0] r);
        if (used && r != '0 && exp_q.en && exp_q.gpr_we && exp_q.hart_id == if_hart_id
            && exp_q.rd_addr == r) begin
            return ex_fwd_data;              // EX hit
        end
        if (used && r != '0 && mem_gpr_we && mem_hart_id == if_hart_id && mem_rd_addr == r) begin
            return mem_fwd_data;             // MEM hit
        end
        if (r == '0) begin
            return '0;                       // x0
        end
        return gpr_model[if_hart_id][r];
    endfunction

    task automatic model_step();
        id_ex_t             nxt;
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [`WORD_W-1:0] a;
        logic [`WORD_W-1:0] b;
        alu_op_e            fop;
        logic               flegal;
        logic               illegal;
        opc = if_insn[6:0];
        f3  = if_insn[14:12];
        f7  = if_insn[31:25];
        a   = src_value(opc inside {`OPC_OP, `OPC_OPIMM, `OPC_LOAD, `OPC_STORE, `OPC_BRANCH,
                                    `OPC_JALR}, if_insn[19:15]);
        b   = src_value(opc inside {`OPC_OP, `OPC_STORE, `OPC_BRANCH}, if_insn[24:20]);
        case (f3)                            // funct3 to ALU op
            3'b000:  fop = (opc == `OPC_OP && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
            3'b001:  fop = ALU_SLL;
            3'b010:  fop = ALU_SLT;
            3'b100:  fop = ALU_XOR;
            3'b101:  fop = ALU_SRL;
            3'b110:  fop = ALU_OR;
            3'b111:  fop = ALU_AND;
            default: fop = ALU_NOP;          // funct3 011 has no ALU op
        endcase
        if (f3 == 3'b011) begin
            flegal = 1'b0;                   // SLTU and SLTIU not in the subset
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
            flegal = (f7 == 7'h0);           // Logical shifts only
        end else if (opc == `OPC_OPIMM) begin
            flegal = 1'b1;
        end else if (f3 == 3'b000) begin
            flegal = (f7 == 7'h0) || (f7 == 7'h20);
        end else begin
            flegal = (f7 == 7'h0);
        end
        nxt          = '0;
        illegal      = 1'b0;
        nxt.en       = if_en;
        nxt.hart_id  = if_hart_id;
        nxt.pc       = if_pc;
        nxt.rd_addr  = if_insn[11:7];
        nxt.alu_in_0 = a;
        nxt.alu_in_1 = 32'($signed(if_insn[31:20]));         // I immediate
        case (opc)
            `OPC_OP: begin
                nxt.alu_op   = fop;
                nxt.alu_in_1 = b;
                nxt.gpr_we   = 1'b1;
                illegal      = !flegal;
            end
            `OPC_OPIMM: begin
                nxt.alu_op = fop;
                nxt.gpr_we = 1'b1;
                illegal    = !flegal;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                nxt.alu_op   = ALU_ADD;
                nxt.alu_in_0 = (opc == `OPC_LUI) ? '0 : if_pc;
                nxt.alu_in_1 = {if_insn[31:12], 12'h0};     // U immediate
                nxt.gpr_we   = 1'b1;
            end
            `OPC_LOAD: begin
                nxt.alu_op = ALU_ADD;
                nxt.mem_op = MEM_LW;
                nxt.gpr_we = 1'b1;
            end
            `OPC_STORE: begin
                nxt.alu_op      = ALU_ADD;
                nxt.alu_in_1    = 32'($signed({if_insn[31:25], if_insn[11:7]}));
                nxt.mem_op      = MEM_SW;
                nxt.mem_wr_data = b;
            end
            `OPC_BRANCH: begin
                nxt.alu_in_1 = 32'($signed({if_insn[31], if_insn[7], if_insn[30:25],
                                            if_insn[11:8], 1'b0}));
                nxt.cmp_in_0 = a;
                nxt.cmp_in_1 = b;
                case (f3)
                    3'b000:  nxt.cmp_op = CMP_EQ;
                    3'b001:  nxt.cmp_op = CMP_NE;
                    3'b100:  nxt.cmp_op = CMP_LT;
                    3'b101:  nxt.cmp_op = CMP_GE;
                    default: nxt.cmp_op = CMP_NONE; // Unsigned branches
                endcase
            end
            `OPC_JAL, `OPC_JALR: begin
                nxt.alu_op      = ALU_ADD;
                nxt.alu_in_0    = if_pc;
                nxt.gpr_we      = 1'b1;
                nxt.gpr_wr_data = if_pc + 32'd4;   // Link
                if (opc == `OPC_JAL) begin
                    nxt.alu_in_1   = 32'($signed({if_insn[31], if_insn[19:12], if_insn[20],
                                                  if_insn[30:21], 1'b0}));
                    nxt.jump_taken = 1'b1;
                end else begin
                    nxt.is_jalr = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            nxt.exp_code = EXP_ILLEGAL;
            nxt.gpr_we   = 1'b0;
            nxt.mem_op   = MEM_NONE;
        end
        if (!if_en) begin                    // Empty slot writes nothing
            nxt.gpr_we = 1'b0;
            nxt.mem_op = MEM_NONE;
        end
        if (flush) begin
            exp_q = '0;                      // Bubble
        end else if (!stall) begin
            exp_q = nxt;
        end
        // Bank write after the reads above
        if (wb.we && wb.addr != '0) begin
            gpr_model[wb.hart_id][wb.addr] = wb.data;
        end
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////
    function automatic logic [6:0] pick_opcode(int unsigned idx, logic [6:0] rnd);
        case (idx)
            0:       return `OPC_OP;
            1:       return `OPC_OPIMM;
            2:       return `OPC_LUI;
            3:       return `OPC_AUIPC;
            4:       return `OPC_LOAD;
            5:       return `OPC_STORE;
            6:       return `OPC_BRANCH;
            7:       return `OPC_JAL;
            8:       return `OPC_JALR;
            default: return rnd;             // Mostly illegal
        endcase
    endfunction

    task automatic drive_inputs(input logic active);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        logic [6:0]  f7;
        wb_t         w;
        r = $urandom;
        s = $urandom;
        t = $urandom;
        case (s[1:0])
            2'd2:    f7 = 7'h20;             // SUB pattern
            2'd3:    f7 = r[31:25];
            default: f7 = 7'h0;
        endcase
        // Small register range so hazards are frequent
        if_insn    <= {f7, 2'b00, s[4:2], 2'b00, s[7:5], r[14:12], 2'b00, s[10:8],
                       pick_opcode($urandom % 10, r[6:0])};
        if_hart_id <= s[12 +: `HART_W];
        if_pc      <= $urandom & 32'hffff_fffc;
        if_en      <= active && (s[17:16] != 2'b00);
        stall      <= active && ($urandom % 10 == 0);
        flush      <= active && ($urandom % 10 == 0);
        w.we        = s[18];
        w.hart_id   = s[19 +: `HART_W];
        w.addr      = {2'b00, s[24:22]};
        w.data      = $urandom;
        wb         <= w;
        mem_gpr_we   <= t[0];
        mem_hart_id  <= t[1 +: `HART_W];
        mem_rd_addr  <= {2'b00, t[6:4]};
        ex_fwd_data  <= $urandom;
        mem_fwd_data <= $urandom;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, expv);
            $display(">>> FAIL");
            $fatal(1, "id_ex compare failed");
        end
    endtask

    task automatic compare_all();
        check_val("id_ex.en",          32'(id_ex.en),          32'(exp_q.en));
        check_val("id_ex.hart_id",     32'(id_ex.hart_id),     32'(exp_q.hart_id));
        check_val("id_ex.pc",          id_ex.pc,               exp_q.pc);
        check_val("id_ex.alu_op",      32'(id_ex.alu_op),      32'(exp_q.alu_op));
        check_val("id_ex.alu_in_0",    id_ex.alu_in_0,         exp_q.alu_in_0);
        check_val("id_ex.alu_in_1",    id_ex.alu_in_1,         exp_q.alu_in_1);
        check_val("id_ex.cmp_op",      32'(id_ex.cmp_op),      32'(exp_q.cmp_op));
        check_val("id_ex.cmp_in_0",    id_ex.cmp_in_0,         exp_q.cmp_in_0);
        check_val("id_ex.cmp_in_1",    id_ex.cmp_in_1,         exp_q.cmp_in_1);
        check_val("id_ex.jump_taken",  32'(id_ex.jump_taken),  32'(exp_q.jump_taken));
        check_val("id_ex.is_jalr",     32'(id_ex.is_jalr),     32'(exp_q.is_jalr));
        check_val("id_ex.mem_op",      32'(id_ex.mem_op),      32'(exp_q.mem_op));
        check_val("id_ex.mem_wr_data", id_ex.mem_wr_data,      exp_q.mem_wr_data);
        check_val("id_ex.rd_addr",     32'(id_ex.rd_addr),     32'(exp_q.rd_addr));
        check_val("id_ex.gpr_we",      32'(id_ex.gpr_we),      32'(exp_q.gpr_we));
        check_val("id_ex.gpr_wr_data", id_ex.gpr_wr_data,      exp_q.gpr_wr_data);
        check_val("id_ex.exp_code",    32'(id_ex.exp_code),    32'(exp_q.exp_code));
    endtask

    initial begin
        int cyc;
        void'($urandom(32'he11edced));
        clk          = 1'b0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        if_en        = 1'b0;
        if_hart_id   = '0;
        if_pc        = '0;
        if_insn      = '0;
        wb           = '0;
        ex_fwd_data  = '0;
        mem_fwd_data = '0;
        mem_hart_id  = '0;
        mem_rd_addr  = '0;
        mem_gpr_we   = 1'b0;
        exp_q        = '0;
        foreach (gpr_model[h, r]) begin
            gpr_model[h][r] = '0;
        end
        for (cyc = 0; cyc < 4; cyc++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        drive_inputs(1'b1);
        @(negedge clk);
        check_val("id_ex.en after reset",     32'(id_ex.en),     32'd0);
        check_val("id_ex.gpr_we after reset", 32'(id_ex.gpr_we), 32'd0);
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_step();                    // Inputs still hold pre-edge values
            drive_inputs(1'b1);
            @(negedge clk);
            compare_all();
        end
        // Drain with fetch idle
        for (cyc = 0; cyc < DRAIN_MAX; cyc++) begin
            @(posedge clk);
            model_step();
            drive_inputs(1'b0);
            @(negedge clk);
            compare_all();
            if (!id_ex.en) begin
                break;
            end
        end
        if (id_ex.en) begin
            $display("Timeout: ID/EX slot still valid after fetch went idle");
            $display(">>> FAIL");
            $fatal(1, "drain timeout");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+.
core_pkg.sv
gpr_file.sv
fwd_unit.sv
decoder.sv
id_reg.sv
id_stage.sv
decode_top.sv
tb_decode_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_decode_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := >>> PASS

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -F -- "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
